// File: hdl/fnd_pkg.sv
package fnd_pkg;

    ////////////////////////////////////////////////////////////
    // display geometry
    ////////////////////////////////////////////////////////////

    localparam int unsigned DISPLAY_WIDTH = 16; // counter bits shown on the display
    localparam int unsigned NIBBLE_WIDTH  = 4;  // one hex digit
    localparam int unsigned NUM_DIGITS    = 4;  // digits on the module

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef logic [NIBBLE_WIDTH-1:0] nibble_t;

    // active low, bit 7 = a ... bit 1 = g, bit 0 = dp
    typedef logic [7:0] seg_t;

    // active low anode enables, bit 0 = rightmost digit
    typedef logic [NUM_DIGITS-1:0] com_t;

    // scan states, DIGIT_0 carries the lowest nibble
    typedef enum logic [1:0] {
        DIGIT_0 = 2'd0,
        DIGIT_1 = 2'd1,
        DIGIT_2 = 2'd2,
        DIGIT_3 = 2'd3
    } digit_e;

    // everything the display pins need in one cycle
    typedef struct packed {
        com_t com;
        seg_t seg;
    } fnd_drive_t;

    ////////////////////////////////////////////////////////////
    // idle values
    ////////////////////////////////////////////////////////////

    localparam seg_t SEG_BLANK = 8'hff; // all segments dark, dp included
    localparam com_t COM_NONE  = '1;    // no anode driven

endpackage

// File: hdl/digit_scanner.sv
`timescale 1ns/1ps

module digit_scanner #(
    parameter int unsigned SCAN_DIV_BITS = 17
) (
    input  logic            clk,
    input  logic            reset_p,
    output fnd_pkg::digit_e digit
);

    import fnd_pkg::*;

    logic [SCAN_DIV_BITS-1:0] prescaler;
    logic                     ff_cur;    // current copy of the prescaler msb
    logic                     ff_old;    // one cycle older
    logic                     scan_tick;

    // free-running divider, wraps every 2**SCAN_DIV_BITS cycles
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            prescaler <= '0;
        end else begin
            prescaler <= prescaler + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // rising edge of the divider msb
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            ff_cur <= 1'b0;
            ff_old <= 1'b0;
        end else begin
            ff_cur <= prescaler[SCAN_DIV_BITS-1];
            ff_old <= ff_cur;
        end
    end

    assign scan_tick = ff_cur & ~ff_old; // single cycle, no ack

    // digit ring 0 -> 1 -> 2 -> 3 -> 0
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            digit <= DIGIT_0;
        end else if (scan_tick) begin
            case (digit)
                DIGIT_0: digit <= DIGIT_1;
                DIGIT_1: digit <= DIGIT_2;
                DIGIT_2: digit <= DIGIT_3;
                default: digit <= DIGIT_0;
            endcase
        end
    end

endmodule

// File: hdl/hex_counter.sv
`timescale 1ns/1ps

module hex_counter #(
    parameter int unsigned COUNT_WIDTH = 32
) (
    input  logic                              clk,
    input  logic                              reset_p,
    input  fnd_pkg::digit_e                   digit,
    output logic [fnd_pkg::DISPLAY_WIDTH-1:0] count,
    output fnd_pkg::nibble_t                  nibble,
    output fnd_pkg::digit_e                   digit_q
);

    import fnd_pkg::*;

    logic [COUNT_WIDTH-1:0] counter;
    nibble_t                nibble_sel;

    ////////////////////////////////////////////////////////////
    // wide up-counter, only the slow upper bits are shown
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    assign count = counter[COUNT_WIDTH-1 -: DISPLAY_WIDTH];

    // pick the hex digit the ring is pointing at
    always_comb begin
        case (digit)
            DIGIT_0: nibble_sel = count[0*NIBBLE_WIDTH +: NIBBLE_WIDTH];
            DIGIT_1: nibble_sel = count[1*NIBBLE_WIDTH +: NIBBLE_WIDTH];
            DIGIT_2: nibble_sel = count[2*NIBBLE_WIDTH +: NIBBLE_WIDTH];
            default: nibble_sel = count[3*NIBBLE_WIDTH +: NIBBLE_WIDTH];
        endcase
    end

    // nibble and its digit move together so the anode never runs ahead
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            nibble  <= '0;
            digit_q <= DIGIT_0;
        end else begin
            nibble  <= nibble_sel;
            digit_q <= digit;
        end
    end

endmodule

// File: hdl/seg7_decoder.sv
`timescale 1ns/1ps

module seg7_decoder (
    input  logic                 clk,
    input  logic                 reset_p,
    input  fnd_pkg::nibble_t     nibble,
    input  fnd_pkg::digit_e      digit_q,
    output fnd_pkg::fnd_drive_t  fnd
);

    import fnd_pkg::*;

    seg_t seg_next;
    com_t com_next;

    ////////////////////////////////////////////////////////////
    // hex glyphs, active low, order a b c d e f g dp
    ////////////////////////////////////////////////////////////

    function automatic seg_t hex_glyph(input nibble_t value);
        seg_t glyph;
        case (value)
            4'h0: glyph = 8'b0000_0011;
            4'h1: glyph = 8'b1001_1111; // b c only
            4'h2: glyph = 8'b0010_0101;
            4'h3: glyph = 8'b0000_1101;
            4'h4: glyph = 8'b1001_1001;
            4'h5: glyph = 8'b0100_1001;
            4'h6: glyph = 8'b0100_0001;
            4'h7: glyph = 8'b0001_1111; // a b c
            4'h8: glyph = 8'b0000_0001; // everything but dp
            4'h9: glyph = 8'b0000_1001;
            4'ha: glyph = 8'b0001_0001; // upper case A
            4'hb: glyph = 8'b1100_0001; // lower case b
            4'hc: glyph = 8'b0110_0011; // upper case C
            4'hd: glyph = 8'b1000_0101; // lower case d
            4'he: glyph = 8'b0110_0001;
            default: glyph = 8'b0111_0001; // F
        endcase
        return glyph;
    endfunction

    // one low anode per scan state
    function automatic com_t digit_anode(input digit_e sel);
        com_t anode;
        case (sel)
            DIGIT_0: anode = 4'b1110;
            DIGIT_1: anode = 4'b1101;
            DIGIT_2: anode = 4'b1011;
            default: anode = 4'b0111;
        endcase
        return anode;
    endfunction

    assign seg_next = hex_glyph(nibble);
    assign com_next = digit_anode(digit_q);

    ////////////////////////////////////////////////////////////
    // output register, anode and segments switch on the same edge
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            fnd.com <= COM_NONE; // display dark until the first digit
            fnd.seg <= SEG_BLANK;
        end else begin
            fnd.com <= com_next;
            fnd.seg <= seg_next;
        end
    end

endmodule

// File: hdl/fnd_counter_top.sv
`timescale 1ns/1ps

module fnd_counter_top #(
    parameter int unsigned COUNT_WIDTH   = 32,
    parameter int unsigned SCAN_DIV_BITS = 17
) (
    input  logic                              clk,
    input  logic                              reset_p,
    output logic [fnd_pkg::DISPLAY_WIDTH-1:0] count,
    output fnd_pkg::fnd_drive_t               fnd
);

    import fnd_pkg::*;

    digit_e  digit;   // scan state from the ring
    nibble_t nibble;  // registered hex digit
    digit_e  digit_q; // digit the nibble belongs to

    ////////////////////////////////////////////////////////////
    // scan ring, counter, decoder
    ////////////////////////////////////////////////////////////

    digit_scanner #(
        .SCAN_DIV_BITS (SCAN_DIV_BITS)
    ) digit_scanner_inst (
        .clk     (clk),
        .reset_p (reset_p),
        .digit   (digit)
    );

    hex_counter #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) hex_counter_inst (
        .clk     (clk),
        .reset_p (reset_p),
        .digit   (digit),
        .count   (count),
        .nibble  (nibble),
        .digit_q (digit_q)
    );

    seg7_decoder seg7_decoder_inst (
        .clk     (clk),
        .reset_p (reset_p),
        .nibble  (nibble),
        .digit_q (digit_q),
        .fnd     (fnd)
    );

endmodule

// File: tests/fnd_counter_checker.sv
`timescale 1ns/1ps

module fnd_counter_checker (
    input logic                clk,
    input logic                reset_p,
    input fnd_pkg::fnd_drive_t fnd
);

    import fnd_pkg::*;

    // next anode in the scan order
    function automatic com_t next_anode(input com_t com);
        return {com[NUM_DIGITS-2:0], com[NUM_DIGITS-1]};
    endfunction

    function automatic logic one_low(input com_t com);
        return $countones(~com) == 1;
    endfunction

    ////////////////////////////////////////////////////////////
    // display outputs
    ////////////////////////////////////////////////////////////

    anode_single: assert property (@(posedge clk)
        fnd.com == COM_NONE || one_low(fnd.com))
        else $error("anode pattern %b enables more than one digit", fnd.com);

    dark_when_idle: assert property (@(posedge clk)
        fnd.com == COM_NONE |-> fnd.seg == SEG_BLANK)
        else $error("segments %b lit while no anode is driven", fnd.seg);

    // only legal digit steps, the reset release is excluded
    scan_successor: assert property (@(posedge clk) disable iff (reset_p)
        (one_low(fnd.com) && one_low($past(fnd.com)) && fnd.com != $past(fnd.com))
            |-> fnd.com == next_anode($past(fnd.com)))
        else $error("anode jumped from %b to %b", $past(fnd.com), fnd.com);

endmodule

// File: tests/fnd_counter_tb.sv
`timescale 1ns/1ps

module fnd_counter_tb;

    import fnd_pkg::*;

    localparam int COUNT_WIDTH   = 20;
    localparam int SCAN_DIV_BITS = 3;
    localparam int SCAN_PERIOD   = 1 << SCAN_DIV_BITS; // cycles between anode steps
    localparam int SHIFT         = COUNT_WIDTH - DISPLAY_WIDTH;

    localparam int RESET_CYCLES = 10;
    localparam int FREE_CYCLES  = 200; // per free-running test
    localparam int PULSES       = 12;  // random mid-run resets
    localparam int GAP_MIN      = 24;
    localparam int GAP_SPAN     = 48;
    localparam int PULSE_MAX    = 4;
    localparam int TAIL_CYCLES  = 40;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + 2 * FREE_CYCLES
                                + PULSES * (GAP_MIN + GAP_SPAN + PULSE_MAX) + TAIL_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES;

    logic                     clk;
    logic                     reset_p;
    logic [DISPLAY_WIDTH-1:0] count;
    fnd_drive_t               fnd;

    // reference model
    logic [COUNT_WIDTH-1:0]   model_cnt;     // rising edges since release
    logic [COUNT_WIDTH-1:0]   cnt_d1;
    logic [COUNT_WIDTH-1:0]   cnt_d2;        // what the segments show now
    com_t                     prev_com;
    int                       since_change;
    bit                       gap_valid;     // first step after reset has its own delay
    logic [DISPLAY_WIDTH-1:0] prev_count;

    int     scan_changes;
    int     count_changes;
    int     seg_checks;
    int     errors;
    int     checks;
    int     cycle_count;
    integer seed;

    fnd_counter_top #(
        .COUNT_WIDTH   (COUNT_WIDTH),
        .SCAN_DIV_BITS (SCAN_DIV_BITS)
    ) fnd_counter_top_inst (
        .clk     (clk),
        .reset_p (reset_p),
        .count   (count),
        .fnd     (fnd)
    );

    bind fnd_counter_top fnd_counter_checker fnd_counter_checker_inst (
        .clk     (clk),
        .reset_p (reset_p),
        .fnd     (fnd)
    );

    always #10 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: the run went past %0d cycles without finishing",
                     TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // model helpers
    ////////////////////////////////////////////////////////////

    // lit segments in order a b c d e f g, pins are active low with dp off
    function automatic seg_t glyph_of(input nibble_t value);
        logic [6:0] lit;
        case (value)
            4'h0: lit = 7'b1111110;
            4'h1: lit = 7'b0110000;
            4'h2: lit = 7'b1101101;
            4'h3: lit = 7'b1111001;
            4'h4: lit = 7'b0110011;
            4'h5: lit = 7'b1011011;
            4'h6: lit = 7'b1011111;
            4'h7: lit = 7'b1110000;
            4'h8: lit = 7'b1111111;
            4'h9: lit = 7'b1111011;
            4'ha: lit = 7'b1110111; // A
            4'hb: lit = 7'b0011111; // b
            4'hc: lit = 7'b1001110; // C
            4'hd: lit = 7'b0111101; // d
            4'he: lit = 7'b1001111; // E
            default: lit = 7'b1000111; // F
        endcase
        return {~lit, 1'b1};
    endfunction

    function automatic int low_count(input com_t com);
        int n;
        int i;
        n = 0;
        for (i = 0; i < NUM_DIGITS; i++) begin
            if (!com[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic int low_index(input com_t com);
        int idx;
        int i;
        idx = 0;
        for (i = 0; i < NUM_DIGITS; i++) begin
            if (!com[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // the low bit walks up one place per step and wraps
    function automatic com_t next_anode(input com_t com);
        return {com[NUM_DIGITS-2:0], com[NUM_DIGITS-1]};
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one clock cycle, sampled at the falling edge
    ////////////////////////////////////////////////////////////

    task automatic step_cycle();
        com_t                     com_now;
        logic [DISPLAY_WIDTH-1:0] word_d2;
        nibble_t                  shown;
        int                       idx;
        @(negedge clk);
        com_now = fnd.com;
        cnt_d2  = cnt_d1;
        cnt_d1  = model_cnt;
        if (reset_p) begin
            model_cnt    = '0; // pipeline registers clear with the counter
            cnt_d1       = '0;
            cnt_d2       = '0;
            gap_valid    = 1'b0;
            since_change = 0;
            check_equal(32'(com_now), 32'(COM_NONE), "anodes off in reset");
            check_equal(32'(fnd.seg), 32'(SEG_BLANK), "segments blank in reset");
        end else begin
            model_cnt = model_cnt + 1'b1;
            since_change++;
        end

        check_equal(32'(count), 32'(DISPLAY_WIDTH'(model_cnt >> SHIFT)), "display word");
        if (count !== prev_count) begin
            count_changes++;
        end
        prev_count = count;

        if (!reset_p) begin
            check_equal(32'(low_count(com_now)), 32'd1, "exactly one anode low");
            if (low_count(com_now) == 1) begin
                idx     = low_index(com_now);
                word_d2 = DISPLAY_WIDTH'(cnt_d2 >> SHIFT);
                shown   = word_d2[idx*NIBBLE_WIDTH +: NIBBLE_WIDTH];
                check_equal(32'(fnd.seg), 32'(glyph_of(shown)), "segment pattern");
                check_equal(32'(fnd.seg[0]), 32'd1, "decimal point off");
                seg_checks++;
            end
        end

        if (com_now !== prev_com) begin
            if (low_count(com_now) == 1 && low_count(prev_com) == 1) begin
                check_equal(32'(com_now), 32'(next_anode(prev_com)), "scan order");
                if (gap_valid) begin
                    check_equal(32'(since_change), 32'(SCAN_PERIOD), "scan period");
                end
                gap_valid = 1'b1;
                scan_changes++;
            end
            since_change = 0;
        end
        prev_com = com_now;
    endtask

    task automatic run_cycles(input int cycles);
        repeat (cycles) step_cycle();
    endtask

    task automatic hold_reset(input int cycles);
        reset_p = 1'b1;
        run_cycles(cycles);
        reset_p = 1'b0; // released on the falling edge
    endtask

    task automatic report_test(input string name, input int start_errors);
        $display("test %-18s done, %0d errors", name, errors - start_errors);
    endtask

    task automatic random_resets();
        int p;
        int gap;
        int len;
        for (p = 0; p < PULSES; p++) begin
            gap = GAP_MIN + int'($unsigned($random(seed)) % GAP_SPAN);
            len = 1 + int'($unsigned($random(seed)) % PULSE_MAX);
            run_cycles(gap);
            hold_reset(len);
        end
        run_cycles(TAIL_CYCLES); // last recovery
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int start;
        clk           = 1'b0;
        reset_p       = 1'b1;
        seed          = 32'hc19393c8;
        model_cnt     = '0;
        cnt_d1        = '0;
        cnt_d2        = '0;
        prev_com      = COM_NONE;
        since_change  = 0;
        gap_valid     = 1'b0;
        prev_count    = '0;
        scan_changes  = 0;
        count_changes = 0;
        seg_checks    = 0;
        errors        = 0;
        checks        = 0;
        cycle_count   = 0;

        start = errors;
        hold_reset(RESET_CYCLES);
        run_cycles(1); // first sample after release
        report_test("reset_state", start);

        start         = errors;
        count_changes = 0;
        run_cycles(FREE_CYCLES);
        if (count_changes < 8) begin
            errors++;
            $display("the display word changed only %0d times in the counter test",
                     count_changes);
        end
        report_test("counter", start);

        start        = errors;
        scan_changes = 0;
        seg_checks   = 0;
        run_cycles(FREE_CYCLES);
        if (scan_changes < FREE_CYCLES / SCAN_PERIOD - 2 || seg_checks < FREE_CYCLES) begin
            errors++;
            $display("too few digit steps (%0d) or segment checks (%0d) in the scan test",
                     scan_changes, seg_checks);
        end
        report_test("segments_and_scan", start);

        start = errors;
        random_resets();
        report_test("random_resets", start);

        $display("4 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
hdl/fnd_pkg.sv
hdl/digit_scanner.sv
hdl/hex_counter.sv
hdl/seg7_decoder.sv
hdl/fnd_counter_top.sv
tests/fnd_counter_checker.sv
tests/fnd_counter_tb.sv

// File: Makefile
VERILATOR  = verilator
TOP        = fnd_counter_tb
FILELIST   = tb.f
BUILD_DIR  = obj_dir
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert -Wall
PASS_MSG   = Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run passes only if the pass line shows up in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
